/* files.f */
+incdir+verilog
verilog/float_pkg.sv
verilog/cordic_pkg.sv
verilog/float_to_fixed.sv
verilog/cordic_rotation.sv
verilog/cordic_pipeline.sv
verilog/fixed_to_float.sv
verilog/cordic_cos.sv
bench/cordic_cos_checker.sv
bench/cordic_cos_tb.sv

/* bench/cordic_cos_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module cordic_cos_tb;

    localparam int num_vectors    = 3000;
    localparam int timeout_cycles = num_vectors * 2 + 100;

    logic        clock;
    logic        arst_n;
    logic        clk_en;
    logic [31:0] dataa;
    logic [31:0] result;
    logic [31:0] lfsr_state;
    int          error_count;
    int          check_count;
    int          cycle_count;

    cordic_cos dut_i (
        .clock (clock),
        .arst_n(arst_n),
        .clk_en(clk_en),
        .dataa (dataa),
        .result(result)
    );

    cordic_cos_checker chk_i (
        .clock      (clock),
        .arst_n     (arst_n),
        .clk_en     (clk_en),
        .dataa      (dataa),
        .result     (result),
        .error_count(error_count),
        .check_count(check_count)
    );

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? (state >> 1) ^ 32'h8020_0003 : state >> 1;
    endfunction

    function automatic logic [31:0] draw_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);  // one step per bit
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic apply_vector(input int index);
        logic [1:0]  en_bits;
        logic [31:0] raw;
        logic [7:0]  exponent;
        logic [31:0] special;
        logic        use_special;
        en_bits = 2'(draw_bits(2));
        raw = draw_bits(32);
        // mostly 100..126 so the angle lands in range
        exponent = (raw[30:28] != 3'b000) ? 8'(100 + raw[27:23] % 27) : raw[30:23];
        clk_en = |en_bits;
        dataa = {raw[31], exponent, raw[22:0]};
        if ((index >= 500 && index < 512) || (index >= 1500 && index < 1506)) begin
            clk_en = 1'b0;  // long stalls
        end
        use_special = 1'b1;
        case (index)
            20:      special = 32'h0000_0000;
            21:      special = 32'h8000_0000;
            40:      special = 32'h3F80_0000;  // +1.0
            41:      special = 32'hBF80_0000;
            60:      special = 32'h7F80_0000;  // infinities
            61:      special = 32'hFF80_0000;
            80:      special = 32'h7FC0_0000;  // nan
            100:     special = 32'h0001_2345;  // denormal
            120:     special = 32'h3380_0000;  // 2^-24, below one lsb
            121:     special = 32'h3580_0000;  // exactly one lsb
            default: use_special = 1'b0;
        endcase
        if (use_special) begin
            dataa = special;
            clk_en = 1'b1;
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        arst_n = 1'b0;
        clk_en = 1'b0;
        dataa = '0;
        lfsr_state = 32'd27;
        repeat (16) @(posedge clock);
        #1 arst_n = 1'b1;
        for (int v = 0; v < num_vectors; v++) begin
            @(posedge clock);
            #1 apply_vector(v);
        end
        repeat (3) @(posedge clock);
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial cycle_count = 0;

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("run did not finish within %0d cycles", timeout_cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* bench/cordic_cos_checker.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cordic_macros.svh"

module cordic_cos_checker import cordic_pkg::*; (
    input  logic        clock,
    input  logic        arst_n,
    input  logic        clk_en,
    input  logic [31:0] dataa,
    input  logic [31:0] result,
    output int          error_count,
    output int          check_count
);

    localparam int max_mag = (1 << `CORDIC_FRAC) - 1;

    logic [31:0] newer_word;   // taken at the last enabled edge
    logic [31:0] older_word;   // taken one enabled edge before that
    logic        newer_valid;
    logic        older_valid;
    logic        edge_enabled;
    logic        have_last;
    logic [31:0] last_result;
    logic [31:0] expected;

    // real value times 2^20 truncated toward zero
    function automatic fixed_t model_angle(input logic [31:0] word);
        int  e;
        int  sig;
        int  mag;
        real scaled;
        e = word[30:23];
        sig = {1'b1, word[22:0]};
        if (e == 0) return '0;
        if (e >= 127) return word[31] ? fixed_t'(-max_mag) : fixed_t'(max_mag);
        scaled = sig * (2.0 ** (e - 130));  // below 2^-20 this is under one
        mag = $rtoi(scaled);
        return word[31] ? fixed_t'(-mag) : fixed_t'(mag);
    endfunction

    // atan(2^-stage) in s0.20
    function automatic fixed_t stage_angle(input int stage);
        case (stage)
            0:       return 21'h0C90FE;
            1:       return 21'h076B1A;
            2:       return 21'h03EB6F;
            3:       return 21'h01FD5C;
            4:       return 21'h00FFAB;
            5:       return 21'h007FF5;
            6:       return 21'h003FFF;
            7:       return 21'h002000;
            8:       return 21'h001000;
            9:       return 21'h000800;
            10:      return 21'h000400;
            11:      return 21'h000200;
            12:      return 21'h000100;
            13:      return 21'h000080;
            14:      return 21'h000040;
            15:      return 21'h000020;
            default: return '0;
        endcase
    endfunction

    function automatic fixed_t model_cordic(input fixed_t angle);
        fixed_t x;
        fixed_t y;
        fixed_t z;
        fixed_t x_next;
        fixed_t y_next;
        x = `CORDIC_GAIN;
        y = '0;
        z = angle;
        for (int i = 0; i < `CORDIC_STAGES; i++) begin
            if (z >= 0) begin
                x_next = x - (y >>> i);
                y_next = y + (x >>> i);
                z = z - stage_angle(i);
            end else begin
                x_next = x + (y >>> i);
                y_next = y - (x >>> i);
                z = z + stage_angle(i);
            end
            x = x_next;
            y = y_next;
        end
        return x;
    endfunction

    function automatic logic [31:0] model_float(input fixed_t value);
        logic [20:0] mag;
        logic [20:0] rest;
        int          p;
        if (value == '0) return 32'h0;
        mag = value[20] ? 21'(-value) : value;
        p = 20;
        while (!mag[p]) p--;
        rest = mag;
        rest[p] = 1'b0;  // hidden one
        return {value[20], 8'(107 + p), 23'({2'b00, rest} << (23 - p))};
    endfunction

    // enabled-edge model of the two banks
    always @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            newer_word   <= '0;
            older_word   <= '0;
            newer_valid  <= 1'b0;
            older_valid  <= 1'b0;
            edge_enabled <= 1'b0;
        end else begin
            edge_enabled <= clk_en;
            if (clk_en) begin
                older_word  <= newer_word;
                older_valid <= newer_valid;
                newer_word  <= dataa;
                newer_valid <= 1'b1;
            end
        end
    end

    initial begin
        error_count = 0;
        check_count = 0;
        have_last = 1'b0;
    end

    // result is settled mid-cycle
    always @(negedge clock) begin
        if (!arst_n) begin
            have_last = 1'b0;
        end else begin
            expected = older_valid ? model_float(model_cordic(model_angle(older_word))) : '0;
            check_count++;
            if (result !== expected) begin
                error_count++;
                $display("ERR t=%0t result expected=%08h actual=%08h", $time, expected, result);
            end
            if (have_last && !edge_enabled && result !== last_result) begin
                error_count++;
                $display("ERR t=%0t result held=%08h actual=%08h", $time, last_result, result);
            end
            last_result = result;
            have_last = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/cordic_cos.sv */
`timescale 1ns/100ps
`default_nettype none

module cordic_cos import cordic_pkg::*; (
    input  logic        clock,
    input  logic        arst_n,
    input  logic        clk_en,
    input  logic [31:0] dataa,   // angle in radians, single float
    output logic [31:0] result   // cosine, single float
);

    fixed_t angle;
    fixed_t cosine;

    float_to_fixed float_to_fixed_i (
        .dataa(dataa),
        .angle(angle)
    );

    // two enabled edges from angle to cosine
    cordic_pipeline cordic_pipeline_i (
        .clock (clock),
        .arst_n(arst_n),
        .clk_en(clk_en),
        .angle (angle),
        .cosine(cosine)
    );

    fixed_to_float fixed_to_float_i (
        .cosine(cosine),
        .result(result)
    );

endmodule

`default_nettype wire

/* verilog/fixed_to_float.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cordic_macros.svh"

module fixed_to_float import float_pkg::*, cordic_pkg::*; (
    input  fixed_t   cosine,
    output float32_u result
);

    // value 2^p * 2^-20 gives exponent field 127 - 20 + p
    localparam logic [7:0] exp_base = 8'(127 - `CORDIC_FRAC);

    logic [`CORDIC_WIDTH-1:0] magnitude;  // unsigned, -2^20 becomes 2^20
    logic [4:0]               lead;
    logic [23:0]              aligned;

    assign magnitude = cosine[`CORDIC_WIDTH-1] ? -cosine : cosine;

    // priority search, highest set bit wins
    always_comb begin
        lead = '0;
        for (int i = 0; i < `CORDIC_WIDTH; i++) begin
            if (magnitude[i]) begin
                lead = 5'(i);
            end
        end
    end

    // move the leading one to bit 23 so the bits below it fill the mantissa
    assign aligned = {3'b000, magnitude} << (5'd23 - lead);

    always_comb begin
        result.word = '0;  // zero maps to +0
        if (cosine != '0) begin
            result.bits.sign     = cosine[`CORDIC_WIDTH-1];
            result.bits.exponent = exp_base + 8'(lead);
            result.bits.mantissa = aligned[22:0];  // hidden one dropped
        end
    end

endmodule

`default_nettype wire

/* verilog/cordic_pipeline.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cordic_macros.svh"

module cordic_pipeline import cordic_pkg::*; (
    input  logic   clock,
    input  logic   arst_n,
    input  logic   clk_en,
    input  fixed_t angle,
    output fixed_t cosine
);

    // per-stage inputs and outputs
    fixed_t x_in  [`CORDIC_STAGES];
    fixed_t y_in  [`CORDIC_STAGES];
    fixed_t z_in  [`CORDIC_STAGES];
    fixed_t x_out [`CORDIC_STAGES];
    fixed_t y_out [`CORDIC_STAGES];
    fixed_t z_out [`CORDIC_STAGES];

    fixed_t bank0_x;
    fixed_t bank0_y;
    fixed_t bank0_z;
    fixed_t bank1_x;
    fixed_t bank1_y;
    fixed_t bank1_z;

    genvar i;
    generate
        for (i = 0; i < `CORDIC_STAGES; i++) begin : g_stage
            if (i == 0) begin : g_first
                assign x_in[i] = `CORDIC_GAIN;  // pre-scaled so no gain fix at the end
                assign y_in[i] = '0;
                assign z_in[i] = angle;
            end else if (i == `CORDIC_BANK0 + 1) begin : g_after_bank0
                assign x_in[i] = bank0_x;
                assign y_in[i] = bank0_y;
                assign z_in[i] = bank0_z;
            end else if (i == `CORDIC_BANK1 + 1) begin : g_after_bank1
                assign x_in[i] = bank1_x;
                assign y_in[i] = bank1_y;
                assign z_in[i] = bank1_z;
            end else begin : g_chain
                assign x_in[i] = x_out[i-1];
                assign y_in[i] = y_out[i-1];
                assign z_in[i] = z_out[i-1];
            end

            cordic_rotation #(
                .stage(i)
            ) rotation_i (
                .x_in (x_in[i]),
                .y_in (y_in[i]),
                .z_in (z_in[i]),
                .x_out(x_out[i]),
                .y_out(y_out[i]),
                .z_out(z_out[i])
            );
        end
    endgenerate

    // both banks advance together and hold while clk_en is low
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            bank0_x <= '0;
            bank0_y <= '0;
            bank0_z <= '0;
            bank1_x <= '0;
            bank1_y <= '0;
            bank1_z <= '0;
        end else if (clk_en) begin
            bank0_x <= x_out[`CORDIC_BANK0];
            bank0_y <= y_out[`CORDIC_BANK0];
            bank0_z <= z_out[`CORDIC_BANK0];
            bank1_x <= x_out[`CORDIC_BANK1];
            bank1_y <= y_out[`CORDIC_BANK1];
            bank1_z <= z_out[`CORDIC_BANK1];
        end
    end

    assign cosine = x_out[`CORDIC_STAGES-1];  // sine in y is not used

endmodule

`default_nettype wire

/* verilog/cordic_rotation.sv */
`timescale 1ns/100ps
`default_nettype none

module cordic_rotation import cordic_pkg::*; #(
    parameter int stage = 0
) (
    input  fixed_t x_in,
    input  fixed_t y_in,
    input  fixed_t z_in,
    output fixed_t x_out,
    output fixed_t y_out,
    output fixed_t z_out
);

    localparam fixed_t atan_angle = cordic_atan(stage);

    fixed_t x_shift;
    fixed_t y_shift;
    logic   rotate_neg;

    assign x_shift    = x_in >>> stage;  // arithmetic, keeps sign
    assign y_shift    = y_in >>> stage;
    assign rotate_neg = (z_in < 0);      // residue below zero, turn back

    // all sums wrap at the fixed_t width
    assign x_out = rotate_neg ? x_in + y_shift : x_in - y_shift;
    assign y_out = rotate_neg ? y_in - x_shift : y_in + x_shift;
    assign z_out = rotate_neg ? z_in + atan_angle : z_in - atan_angle;

endmodule

`default_nettype wire

/* verilog/float_to_fixed.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cordic_macros.svh"

module float_to_fixed import float_pkg::*, cordic_pkg::*; (
    input  float32_u dataa,
    output fixed_t   angle
);

    localparam logic [7:0] exp_one = 8'd127;                  // |v| >= 1.0 from here
    localparam logic [7:0] exp_min = 8'(127 - `CORDIC_FRAC);  // 2^-20, one lsb
    // v * 2^20 = significand * 2^(e - shift_base)
    localparam logic [7:0] shift_base = 8'(127 + 23 - `CORDIC_FRAC);
    localparam fixed_t max_mag = fixed_t'({`CORDIC_FRAC{1'b1}});

    logic [23:0]             significand;
    logic [7:0]              shift;
    logic [23:0]             shifted;
    logic [`CORDIC_FRAC-1:0] truncated;
    fixed_t                  magnitude;

    assign significand = {1'b1, dataa.bits.mantissa};  // restore hidden one
    assign shift       = shift_base - dataa.bits.exponent;
    assign shifted     = significand >> shift;         // truncates toward zero

    // in range the shifted value never exceeds 20 bits
    assign truncated = shifted[`CORDIC_FRAC-1:0];
    assign magnitude = fixed_t'({1'b0, truncated});

    always_comb begin
        if (dataa.bits.exponent < exp_min) begin
            angle = '0;  // zero, denormal or below one lsb
        end else if (dataa.bits.exponent >= exp_one) begin
            // out of range, inf and nan all saturate
            angle = dataa.bits.sign ? -max_mag : max_mag;
        end else begin
            angle = dataa.bits.sign ? -magnitude : magnitude;
        end
    end

endmodule

`default_nettype wire

/* verilog/cordic_pkg.sv */
`default_nettype none

`include "cordic_macros.svh"

package cordic_pkg;

    typedef logic signed [`CORDIC_WIDTH-1:0] fixed_t; // s0.20

    // atan(2^-stage) in fixed_t
    function automatic fixed_t cordic_atan(input int stage);
        case (stage)
            0:       return 21'h0C90FE;
            1:       return 21'h076B1A;
            2:       return 21'h03EB6F;
            3:       return 21'h01FD5C;
            4:       return 21'h00FFAB;
            5:       return 21'h007FF5;
            6:       return 21'h003FFF;
            7:       return 21'h002000;
            8:       return 21'h001000;
            9:       return 21'h000800;
            10:      return 21'h000400;
            11:      return 21'h000200;
            12:      return 21'h000100;
            13:      return 21'h000080;
            14:      return 21'h000040;
            15:      return 21'h000020;
            default: return '0;
        endcase
    endfunction

endpackage

`default_nettype wire

/* verilog/float_pkg.sv */
`default_nettype none

package float_pkg;

    // ieee-754 single precision fields
    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;  // bias 127
        logic [22:0] mantissa;  // hidden one not stored
    } float_bits_t;

    // same word seen raw or split into fields
    typedef union packed {
        logic [31:0] word;
        float_bits_t bits;
    } float32_u;

endpackage

`default_nettype wire

/* verilog/cordic_macros.svh */
`ifndef CORDIC_MACROS_SVH
`define CORDIC_MACROS_SVH

// fixed-point format of x, y and z
`define CORDIC_WIDTH 21
`define CORDIC_FRAC 20

// micro-rotation count and the stages whose outputs are registered
`define CORDIC_STAGES 16
`define CORDIC_BANK0 5
`define CORDIC_BANK1 11

`define CORDIC_GAIN 21'h09B74E // 1/K, start value of x

`endif
